/* common/axil_pkg.sv */
package axil_pkg;

    // Host data path
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    // Write and read response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

endpackage

/* common/emu_regs_pkg.sv */
package emu_regs_pkg;

    // Control port address width
    localparam int CSR_ADDR_W = 12;

    // Register map of the control port
    typedef enum logic [CSR_ADDR_W-1:0] {
        EMU_STAT     = 12'h000,
        EMU_CYCLE_LO = 12'h008,
        EMU_CYCLE_HI = 12'h00C
    } emu_reg_e;

    // EMU_STAT fields
    localparam int STAT_HALT_BIT      = 0;
    localparam int STAT_DUT_RESET_BIT = 1;

    // Emulation cycle counter read as two words
    localparam int CYCLE_W = 64;

    // A processor store here stops emulation
    localparam logic [31:0] TRIGGER_ADDR = 32'h0000_000C;

endpackage

/* src/axil_slave_port.sv */
module axil_slave_port #(
    parameter int ADDR_W      = 12,
    parameter bit STRICT_STRB = 1'b0
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               awvalid,
    output logic                               awready,
    input  logic [ADDR_W-1:0]                  awaddr,
    input  logic                               wvalid,
    output logic                               wready,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]   wdata,
    input  logic [axil_pkg::AXIL_STRB_W-1:0]   wstrb,
    output logic                               bvalid,
    input  logic                               bready,
    output axil_pkg::axil_resp_e               bresp,
    input  logic                               arvalid,
    output logic                               arready,
    input  logic [ADDR_W-1:0]                  araddr,
    output logic                               rvalid,
    input  logic                               rready,
    output logic [axil_pkg::AXIL_DATA_W-1:0]   rdata,
    output axil_pkg::axil_resp_e               rresp,

    output logic                               wr_en,
    output logic [ADDR_W-1:0]                  wr_addr,
    output logic [axil_pkg::AXIL_DATA_W-1:0]   wr_data,
    output logic [axil_pkg::AXIL_STRB_W-1:0]   wr_strb,
    output logic [ADDR_W-1:0]                  rd_addr,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]   rd_data
);

    logic aw_held;
    logic w_held;
    logic ar_held;
    logic commit;
    logic strb_err;
    logic do_read;

    // A new write completes only once the previous response is gone
    assign commit   = aw_held && w_held && !bvalid;
    assign strb_err = STRICT_STRB && (wr_strb != '1);
    assign wr_en    = commit && !strb_err;
    assign do_read  = ar_held && !rvalid;

    assign awready = !aw_held;
    assign wready  = !w_held;
    assign arready = !ar_held;
    assign rresp   = axil_pkg::OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (commit) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_addr <= awaddr;
        end
        if (wvalid && wready) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
        if (commit) begin
            bresp <= strb_err ? axil_pkg::SLVERR : axil_pkg::OKAY;
        end
    end

    // Read side samples data one edge after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_held <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_held <= 1'b1;
            end
            if (do_read) begin
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                ar_held <= 1'b0;
                rvalid  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
        if (do_read) begin
            rdata <= rd_data;
        end
    end

endmodule

/* src/emu_ctrl_regs.sv */
module emu_ctrl_regs (
    input  logic                                  clk,
    input  logic                                  rst,

    input  logic                                  wr_en,
    input  logic [emu_regs_pkg::CSR_ADDR_W-1:0]   wr_addr,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]      wr_data,
    input  logic [emu_regs_pkg::CSR_ADDR_W-1:0]   rd_addr,
    output logic [axil_pkg::AXIL_DATA_W-1:0]      rd_data,

    input  logic [axil_pkg::AXIL_DATA_W-1:0]      dut_addr,
    input  logic                                  dut_wen,

    output logic                                  halt,
    output logic                                  dut_rst
);

    logic                               trigger;
    logic                               wr_stat;
    logic                               wr_cycle_lo;
    logic                               wr_cycle_hi;
    logic [emu_regs_pkg::CYCLE_W-1:0]   cycle;
    logic [axil_pkg::AXIL_DATA_W-1:0]   stat;

    assign trigger     = dut_wen && (dut_addr == emu_regs_pkg::TRIGGER_ADDR);
    assign wr_stat     = wr_en && (wr_addr == emu_regs_pkg::EMU_STAT);
    assign wr_cycle_lo = wr_en && (wr_addr == emu_regs_pkg::EMU_CYCLE_LO);
    assign wr_cycle_hi = wr_en && (wr_addr == emu_regs_pkg::EMU_CYCLE_HI);

    // Processor held in reset and halted until the host releases it
    always_ff @(posedge clk) begin
        if (rst) begin
            halt    <= 1'b1;
            dut_rst <= 1'b1;
        end else if (trigger) begin
            halt <= 1'b1;
        end else if (wr_stat) begin
            halt    <= wr_data[emu_regs_pkg::STAT_HALT_BIT];
            dut_rst <= wr_data[emu_regs_pkg::STAT_DUT_RESET_BIT];
        end
    end

    // Counter runs with emulation and loads from the host only when halted
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!halt) begin
            cycle <= cycle + 1'b1;
        end else begin
            if (wr_cycle_lo) begin
                cycle[axil_pkg::AXIL_DATA_W-1:0] <= wr_data;
            end
            if (wr_cycle_hi) begin
                cycle[emu_regs_pkg::CYCLE_W-1:axil_pkg::AXIL_DATA_W] <= wr_data;
            end
        end
    end

    always_comb begin
        stat = '0;
        stat[emu_regs_pkg::STAT_HALT_BIT]      = halt;
        stat[emu_regs_pkg::STAT_DUT_RESET_BIT] = dut_rst;
    end

    always_comb begin
        case (rd_addr)
            emu_regs_pkg::EMU_STAT:     rd_data = stat;
            emu_regs_pkg::EMU_CYCLE_LO: rd_data = cycle[axil_pkg::AXIL_DATA_W-1:0];
            emu_regs_pkg::EMU_CYCLE_HI: begin
                rd_data = cycle[emu_regs_pkg::CYCLE_W-1:axil_pkg::AXIL_DATA_W];
            end
            default:                    rd_data = '0;
        endcase
    end

endmodule

/* src/emu_mem.sv */
module emu_mem #(
    parameter int DEPTH = 1024
) (
    input  logic                               clk,
    input  logic                               halt,

    input  logic                               host_wen,
    input  logic [$clog2(DEPTH)+1:0]           host_waddr,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]   host_wdata,
    input  logic [axil_pkg::AXIL_STRB_W-1:0]   host_wstrb,
    input  logic [$clog2(DEPTH)+1:0]           host_raddr,
    output logic [axil_pkg::AXIL_DATA_W-1:0]   host_rdata,

    input  logic [axil_pkg::AXIL_DATA_W-1:0]   dut_pc,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]   dut_addr,
    input  logic                               dut_wen,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]   dut_wdata,
    input  logic [axil_pkg::AXIL_STRB_W-1:0]   dut_wstrb,
    output logic [axil_pkg::AXIL_DATA_W-1:0]   dut_instr,
    output logic [axil_pkg::AXIL_DATA_W-1:0]   dut_rdata
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [axil_pkg::AXIL_DATA_W-1:0] mem [DEPTH];

    logic                               sel_wen;
    logic [IDX_W-1:0]                   sel_widx;
    logic [IDX_W-1:0]                   sel_ridx;
    logic [axil_pkg::AXIL_DATA_W-1:0]   sel_wdata;
    logic [axil_pkg::AXIL_STRB_W-1:0]   sel_wstrb;
    logic [axil_pkg::AXIL_DATA_W-1:0]   data_rd;

    // Host owns the memory while halted, processor while running
    assign sel_wen   = halt ? host_wen : dut_wen;
    assign sel_widx  = halt ? host_waddr[IDX_W+1:2] : dut_addr[IDX_W+1:2];
    assign sel_ridx  = halt ? host_raddr[IDX_W+1:2] : dut_addr[IDX_W+1:2];
    assign sel_wdata = halt ? host_wdata : dut_wdata;
    assign sel_wstrb = halt ? host_wstrb : dut_wstrb;

    always_ff @(posedge clk) begin
        for (int i = 0; i < axil_pkg::AXIL_STRB_W; i++) begin
            if (sel_wen && sel_wstrb[i]) begin
                mem[sel_widx][i*8 +: 8] <= sel_wdata[i*8 +: 8];
            end
        end
    end

    assign dut_instr  = mem[dut_pc[IDX_W+1:2]];
    assign data_rd    = mem[sel_ridx];
    assign dut_rdata  = data_rd;
    assign host_rdata = data_rd;

endmodule

/* src/emu_top.sv */
module emu_top #(
    parameter int MEM_DEPTH = 1024
) (
    input  logic                                  clk,
    input  logic                                  rst,

    input  logic                                  csr_awvalid,
    output logic                                  csr_awready,
    input  logic [emu_regs_pkg::CSR_ADDR_W-1:0]   csr_awaddr,
    input  logic                                  csr_wvalid,
    output logic                                  csr_wready,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]      csr_wdata,
    input  logic [axil_pkg::AXIL_STRB_W-1:0]      csr_wstrb,
    output logic                                  csr_bvalid,
    input  logic                                  csr_bready,
    output axil_pkg::axil_resp_e                  csr_bresp,
    input  logic                                  csr_arvalid,
    output logic                                  csr_arready,
    input  logic [emu_regs_pkg::CSR_ADDR_W-1:0]   csr_araddr,
    output logic                                  csr_rvalid,
    input  logic                                  csr_rready,
    output logic [axil_pkg::AXIL_DATA_W-1:0]      csr_rdata,
    output axil_pkg::axil_resp_e                  csr_rresp,

    input  logic                                  mem_awvalid,
    output logic                                  mem_awready,
    input  logic [$clog2(MEM_DEPTH)+1:0]          mem_awaddr,
    input  logic                                  mem_wvalid,
    output logic                                  mem_wready,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]      mem_wdata,
    input  logic [axil_pkg::AXIL_STRB_W-1:0]      mem_wstrb,
    output logic                                  mem_bvalid,
    input  logic                                  mem_bready,
    output axil_pkg::axil_resp_e                  mem_bresp,
    input  logic                                  mem_arvalid,
    output logic                                  mem_arready,
    input  logic [$clog2(MEM_DEPTH)+1:0]          mem_araddr,
    output logic                                  mem_rvalid,
    input  logic                                  mem_rready,
    output logic [axil_pkg::AXIL_DATA_W-1:0]      mem_rdata,
    output axil_pkg::axil_resp_e                  mem_rresp,

    input  logic [axil_pkg::AXIL_DATA_W-1:0]      dut_pc,
    output logic [axil_pkg::AXIL_DATA_W-1:0]      dut_instr,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]      dut_addr,
    input  logic                                  dut_wen,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]      dut_wdata,
    input  logic [axil_pkg::AXIL_STRB_W-1:0]      dut_wstrb,
    output logic [axil_pkg::AXIL_DATA_W-1:0]      dut_rdata,
    output logic                                  dut_halt,
    output logic                                  dut_rst
);

    // Byte address width of the memory port
    localparam int MEM_ADDR_W = $clog2(MEM_DEPTH) + 2;

    logic                                  csr_wr_en;
    logic [emu_regs_pkg::CSR_ADDR_W-1:0]   csr_wr_addr;
    logic [axil_pkg::AXIL_DATA_W-1:0]      csr_wr_data;
    logic [emu_regs_pkg::CSR_ADDR_W-1:0]   csr_rd_addr;
    logic [axil_pkg::AXIL_DATA_W-1:0]      csr_rd_data;

    logic                                  mem_wr_en;
    logic [MEM_ADDR_W-1:0]                 mem_wr_addr;
    logic [axil_pkg::AXIL_DATA_W-1:0]      mem_wr_data;
    logic [axil_pkg::AXIL_STRB_W-1:0]      mem_wr_strb;
    logic [MEM_ADDR_W-1:0]                 mem_rd_addr;
    logic [axil_pkg::AXIL_DATA_W-1:0]      mem_rd_data;

    axil_slave_port #(
        .ADDR_W      (emu_regs_pkg::CSR_ADDR_W),
        .STRICT_STRB (1'b1)
    ) u_csr_port (
        .clk     (clk),
        .rst     (rst),
        .awvalid (csr_awvalid),
        .awready (csr_awready),
        .awaddr  (csr_awaddr),
        .wvalid  (csr_wvalid),
        .wready  (csr_wready),
        .wdata   (csr_wdata),
        .wstrb   (csr_wstrb),
        .bvalid  (csr_bvalid),
        .bready  (csr_bready),
        .bresp   (csr_bresp),
        .arvalid (csr_arvalid),
        .arready (csr_arready),
        .araddr  (csr_araddr),
        .rvalid  (csr_rvalid),
        .rready  (csr_rready),
        .rdata   (csr_rdata),
        .rresp   (csr_rresp),
        .wr_en   (csr_wr_en),
        .wr_addr (csr_wr_addr),
        .wr_data (csr_wr_data),
        .wr_strb (),
        .rd_addr (csr_rd_addr),
        .rd_data (csr_rd_data)
    );

    axil_slave_port #(
        .ADDR_W      (MEM_ADDR_W),
        .STRICT_STRB (1'b0)
    ) u_mem_port (
        .clk     (clk),
        .rst     (rst),
        .awvalid (mem_awvalid),
        .awready (mem_awready),
        .awaddr  (mem_awaddr),
        .wvalid  (mem_wvalid),
        .wready  (mem_wready),
        .wdata   (mem_wdata),
        .wstrb   (mem_wstrb),
        .bvalid  (mem_bvalid),
        .bready  (mem_bready),
        .bresp   (mem_bresp),
        .arvalid (mem_arvalid),
        .arready (mem_arready),
        .araddr  (mem_araddr),
        .rvalid  (mem_rvalid),
        .rready  (mem_rready),
        .rdata   (mem_rdata),
        .rresp   (mem_rresp),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .wr_strb (mem_wr_strb),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data)
    );

    emu_ctrl_regs u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (csr_wr_en),
        .wr_addr  (csr_wr_addr),
        .wr_data  (csr_wr_data),
        .rd_addr  (csr_rd_addr),
        .rd_data  (csr_rd_data),
        .dut_addr (dut_addr),
        .dut_wen  (dut_wen),
        .halt     (dut_halt),
        .dut_rst  (dut_rst)
    );

    emu_mem #(
        .DEPTH (MEM_DEPTH)
    ) u_mem (
        .clk        (clk),
        .halt       (dut_halt),
        .host_wen   (mem_wr_en),
        .host_waddr (mem_wr_addr),
        .host_wdata (mem_wr_data),
        .host_wstrb (mem_wr_strb),
        .host_raddr (mem_rd_addr),
        .host_rdata (mem_rd_data),
        .dut_pc     (dut_pc),
        .dut_addr   (dut_addr),
        .dut_wen    (dut_wen),
        .dut_wdata  (dut_wdata),
        .dut_wstrb  (dut_wstrb),
        .dut_instr  (dut_instr),
        .dut_rdata  (dut_rdata)
    );

endmodule

/* verification/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Address and data go out together, so both readies fall and rise together
task automatic csr_write(input logic [CSR_AW-1:0] addr, input logic [DW-1:0] data,
                         input logic [SW-1:0] strb);
    if (strb == '1) begin
        exp_csr_bresp = axil_pkg::OKAY;
    end else begin
        exp_csr_bresp = axil_pkg::SLVERR;
    end
    @(posedge clk);
    csr_awaddr  <= addr;
    csr_wdata   <= data;
    csr_wstrb   <= strb;
    csr_awvalid <= 1'b1;
    csr_wvalid  <= 1'b1;
    do @(posedge clk); while (!(csr_awready && csr_wready));
    csr_awvalid <= 1'b0;
    csr_wvalid  <= 1'b0;
    do @(posedge clk); while (!(csr_bvalid && csr_bready));
endtask

task automatic csr_read(input logic [CSR_AW-1:0] addr, input logic [DW-1:0] exp,
                        input bit check, output logic [DW-1:0] data);
    exp_csr_rdata = exp;
    csr_rd_chk    = check;
    @(posedge clk);
    csr_araddr  <= addr;
    csr_arvalid <= 1'b1;
    do @(posedge clk); while (!csr_arready);
    csr_arvalid <= 1'b0;
    do @(posedge clk); while (!csr_rvalid);
    data = csr_rdata;
endtask

// Sends address and data without waiting for the response
task automatic send_mem_write(input logic [MEM_AW-1:0] addr, input logic [DW-1:0] data,
                              input logic [SW-1:0] strb);
    @(posedge clk);
    mem_awaddr  <= addr;
    mem_wdata   <= data;
    mem_wstrb   <= strb;
    mem_awvalid <= 1'b1;
    mem_wvalid  <= 1'b1;
    do @(posedge clk); while (!(mem_awready && mem_wready));
    mem_awvalid <= 1'b0;
    mem_wvalid  <= 1'b0;
endtask

task automatic wait_mem_bresp();
    do @(posedge clk); while (!(mem_bvalid && mem_bready));
endtask

task automatic mem_read(input logic [MEM_AW-1:0] addr);
    mem_rd_idx = addr[MEM_AW-1:2];
    @(posedge clk);
    mem_araddr  <= addr;
    mem_arvalid <= 1'b1;
    do @(posedge clk); while (!mem_arready);
    mem_arvalid <= 1'b0;
    do @(posedge clk); while (!mem_rvalid);
endtask

`endif

/* verification/tb_emu_top.sv */
module tb_emu_top;

    localparam int MEM_DEPTH  = 1024;
    localparam int IDX_W      = $clog2(MEM_DEPTH);
    localparam int MEM_AW     = IDX_W + 2;
    localparam int CSR_AW     = emu_regs_pkg::CSR_ADDR_W;
    localparam int DW         = axil_pkg::AXIL_DATA_W;
    localparam int SW         = axil_pkg::AXIL_STRB_W;
    // Well above the length of all tests
    localparam int MAX_CYCLES = 3000;

    logic                 clk;
    logic                 rst;
    logic                 csr_awvalid, csr_wvalid, csr_bready, csr_arvalid, csr_rready;
    logic                 csr_awready, csr_wready, csr_bvalid, csr_arready, csr_rvalid;
    logic [CSR_AW-1:0]    csr_awaddr, csr_araddr;
    logic [DW-1:0]        csr_wdata, csr_rdata;
    logic [SW-1:0]        csr_wstrb;
    axil_pkg::axil_resp_e csr_bresp, csr_rresp;
    logic                 mem_awvalid, mem_wvalid, mem_bready, mem_arvalid, mem_rready;
    logic                 mem_awready, mem_wready, mem_bvalid, mem_arready, mem_rvalid;
    logic [MEM_AW-1:0]    mem_awaddr, mem_araddr;
    logic [DW-1:0]        mem_wdata, mem_rdata;
    logic [SW-1:0]        mem_wstrb;
    axil_pkg::axil_resp_e mem_bresp, mem_rresp;
    logic [DW-1:0]        dut_pc, dut_instr, dut_addr, dut_wdata, dut_rdata;
    logic [SW-1:0]        dut_wstrb;
    logic                 dut_wen, dut_halt, dut_rst;

    logic [DW-1:0]        model [MEM_DEPTH];
    logic [DW-1:0]        exp_csr_rdata;
    axil_pkg::axil_resp_e exp_csr_bresp;
    logic [IDX_W-1:0]     mem_rd_idx;
    logic [63:0]          cyc_first, cyc_second;
    bit                   csr_rd_chk, instr_chk, run_chk, cyc_chk;
    logic                 rst_q;
    string                test_name;
    int                   errors = 0;
    int                   cycles = 0;
    int                   seed;

    emu_top #(.MEM_DEPTH(MEM_DEPTH)) u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        rst_q  <= rst;
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the tests did not complete within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    a_reset_state: assert property (@(posedge clk) rst_q && !rst |-> dut_halt && dut_rst
        && !csr_bvalid && !csr_rvalid && !mem_bvalid && !mem_rvalid && csr_awready
        && csr_wready && csr_arready && mem_awready && mem_wready && mem_arready)
    else begin
        errors++;
        $display("Outputs after reset are wrong: a valid is high, a ready is low or halt is off");
    end

    a_csr_rdata: assert property (@(posedge clk) disable iff (rst)
        csr_rvalid && csr_rready && csr_rd_chk |-> csr_rdata == exp_csr_rdata)
    else begin
        errors++;
        $display("** Error %s: csr rdata expected %h, actual %h", test_name, exp_csr_rdata,
                 $sampled(csr_rdata));
    end

    a_csr_rresp: assert property (@(posedge clk) disable iff (rst)
        csr_rvalid && csr_rready |-> csr_rresp == axil_pkg::OKAY)
    else begin
        errors++;
        $display("** Error %s: csr rresp expected %h, actual %h", test_name, axil_pkg::OKAY,
                 $sampled(csr_rresp));
    end

    a_csr_bresp: assert property (@(posedge clk) disable iff (rst)
        csr_bvalid && csr_bready |-> csr_bresp == exp_csr_bresp)
    else begin
        errors++;
        $display("** Error %s: csr bresp expected %h, actual %h", test_name, exp_csr_bresp,
                 $sampled(csr_bresp));
    end

    a_mem_rdata: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid && mem_rready |-> mem_rdata == model[mem_rd_idx])
    else begin
        errors++;
        $display("** Error %s: mem rdata at word %0d expected %h, actual %h", test_name,
                 mem_rd_idx, model[mem_rd_idx], $sampled(mem_rdata));
    end

    a_mem_rresp: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid && mem_rready |-> mem_rresp == axil_pkg::OKAY)
    else begin
        errors++;
        $display("** Error %s: mem rresp expected %h, actual %h", test_name, axil_pkg::OKAY,
                 $sampled(mem_rresp));
    end

    a_mem_bresp: assert property (@(posedge clk) disable iff (rst)
        mem_bvalid && mem_bready |-> mem_bresp == axil_pkg::OKAY)
    else begin
        errors++;
        $display("** Error %s: mem bresp expected %h, actual %h", test_name, axil_pkg::OKAY,
                 $sampled(mem_bresp));
    end

    // Response must wait for bready
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        $past(mem_bvalid && !mem_bready) |-> mem_bvalid)
    else begin
        errors++;
        $display("** Error %s: mem bvalid expected 1, actual 0", test_name);
    end

    a_trigger: assert property (@(posedge clk) disable iff (rst)
        $past(dut_wen && dut_addr == emu_regs_pkg::TRIGGER_ADDR) |-> dut_halt)
    else begin
        errors++;
        $display("** Error %s: dut_halt expected 1, actual 0", test_name);
    end

    a_running: assert property (@(posedge clk) run_chk |-> !dut_halt && !dut_rst)
    else begin
        errors++;
        $display("** Error %s: halt and dut_rst expected 00, actual %b%b", test_name,
                 $sampled(dut_halt), $sampled(dut_rst));
    end

    // Processor data port sees the memory while it runs
    a_dut_rdata: assert property (@(posedge clk) disable iff (rst)
        !dut_halt && !dut_wen |-> dut_rdata == model[dut_addr[IDX_W+1:2]])
    else begin
        errors++;
        $display("** Error %s: dut_rdata expected %h, actual %h", test_name,
                 model[dut_addr[IDX_W+1:2]], $sampled(dut_rdata));
    end

    a_instr: assert property (@(posedge clk)
        instr_chk |-> dut_instr == model[dut_pc[IDX_W+1:2]])
    else begin
        errors++;
        $display("** Error %s: dut_instr expected %h, actual %h", test_name,
                 model[dut_pc[IDX_W+1:2]], $sampled(dut_instr));
    end

    a_cycle: assert property (@(posedge clk)
        cyc_chk |-> cyc_first == cyc_second && cyc_first != 0)
    else begin
        errors++;
        $display("** Error %s: cycle count expected %h and nonzero, actual %h", test_name,
                 cyc_first, cyc_second);
    end

    `include "tb_axil_tasks.svh"

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
                                                  input logic [DW-1:0] data,
                                                  input logic [SW-1:0] strb);
        logic [DW-1:0] word;
        word = old;
        for (int b = 0; b < SW; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return word;
    endfunction

    // Host memory write that updates the model only when store is set
    task automatic mem_write(input logic [MEM_AW-1:0] addr, input logic [DW-1:0] data,
                             input logic [SW-1:0] strb, input bit store);
        send_mem_write(addr, data, strb);
        wait_mem_bresp();
        if (store) begin
            model[addr[MEM_AW-1:2]] = merge_bytes(model[addr[MEM_AW-1:2]], data, strb);
        end
    endtask

    task automatic dut_store(input logic [DW-1:0] addr, input logic [DW-1:0] data,
                             input logic [SW-1:0] strb);
        @(posedge clk);
        dut_addr  <= addr;
        dut_wdata <= data;
        dut_wstrb <= strb;
        dut_wen   <= 1'b1;
        @(posedge clk);
        dut_wen <= 1'b0;
        model[addr[IDX_W+1:2]] = merge_bytes(model[addr[IDX_W+1:2]], data, strb);
    endtask

    task automatic pulse_check(ref bit flag);
        @(posedge clk);
        flag = 1'b1;
        @(posedge clk);
        @(posedge clk);
        flag = 1'b0;
    endtask

    initial begin
        logic [DW-1:0]    data;
        logic [DW-1:0]    rd_word;
        logic [SW-1:0]    strb;
        logic [IDX_W-1:0] idx;
        seed = 37;
        clk = 1'b0;
        rst = 1'b1;
        {csr_awvalid, csr_wvalid, csr_arvalid, mem_awvalid, mem_wvalid, mem_arvalid} = '0;
        {csr_bready, csr_rready, mem_bready, mem_rready} = '1;
        {csr_awaddr, csr_araddr, csr_wdata, csr_wstrb} = '0;
        {mem_awaddr, mem_araddr, mem_wdata, mem_wstrb} = '0;
        {dut_pc, dut_addr, dut_wdata, dut_wstrb, dut_wen} = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_name = "reset_state";
        csr_read(emu_regs_pkg::EMU_STAT, 32'h3, 1'b1, rd_word);
        csr_read(emu_regs_pkg::EMU_CYCLE_LO, 32'h0, 1'b1, rd_word);
        csr_read(emu_regs_pkg::EMU_CYCLE_HI, 32'h0, 1'b1, rd_word);

        test_name = "counter_access";
        csr_write(emu_regs_pkg::EMU_CYCLE_LO, 32'hFFFF_FFF0, 4'hF);
        csr_write(emu_regs_pkg::EMU_CYCLE_HI, 32'h0000_0001, 4'hF);
        csr_read(emu_regs_pkg::EMU_CYCLE_LO, 32'hFFFF_FFF0, 1'b1, rd_word);
        csr_read(emu_regs_pkg::EMU_CYCLE_HI, 32'h0000_0001, 1'b1, rd_word);
        csr_write(emu_regs_pkg::EMU_CYCLE_HI, 32'hDEAD_BEEF, 4'h3);
        csr_read(emu_regs_pkg::EMU_CYCLE_HI, 32'h0000_0001, 1'b1, rd_word);

        test_name = "host_memory";
        for (int i = 0; i < 16; i++) begin
            idx  = IDX_W'(i);
            data = $random(seed);
            mem_write({idx, 2'b00}, data, 4'hF, 1'b1);
        end
        for (int i = 0; i < 24; i++) begin
            idx  = IDX_W'($random(seed) & 15);
            data = $random(seed);
            strb = SW'($random(seed));
            mem_write({idx, 2'b00}, data, strb, 1'b1);
        end
        for (int i = 0; i < 16; i++) begin
            idx = IDX_W'(i);
            mem_read({idx, 2'b00});
        end
        dut_pc <= '0;
        pulse_check(instr_chk);

        test_name = "run_trigger";
        csr_write(emu_regs_pkg::EMU_CYCLE_LO, 32'h0, 4'hF);
        csr_write(emu_regs_pkg::EMU_CYCLE_HI, 32'h0, 4'hF);
        csr_write(emu_regs_pkg::EMU_STAT, 32'h0, 4'hF);
        pulse_check(run_chk);
        csr_read(emu_regs_pkg::EMU_STAT, 32'h0, 1'b1, rd_word);
        dut_store(32'h10, $random(seed), 4'b0110);
        dut_store(emu_regs_pkg::TRIGGER_ADDR, $random(seed), 4'hF);
        csr_read(emu_regs_pkg::EMU_CYCLE_LO, 32'h0, 1'b0, rd_word);
        cyc_first[31:0] = rd_word;
        csr_read(emu_regs_pkg::EMU_CYCLE_HI, 32'h0, 1'b0, rd_word);
        cyc_first[63:32] = rd_word;
        csr_read(emu_regs_pkg::EMU_CYCLE_LO, 32'h0, 1'b0, rd_word);
        cyc_second[31:0] = rd_word;
        csr_read(emu_regs_pkg::EMU_CYCLE_HI, 32'h0, 1'b0, rd_word);
        cyc_second[63:32] = rd_word;
        pulse_check(cyc_chk);
        mem_read(MEM_AW'(8'h10));
        mem_read(MEM_AW'(8'h0C));

        // Host writes while running are answered but dropped
        test_name = "dropped_write";
        csr_write(emu_regs_pkg::EMU_STAT, 32'h0, 4'hF);
        mem_write(MEM_AW'(8'h20), $random(seed), 4'hF, 1'b0);
        csr_write(emu_regs_pkg::EMU_STAT, 32'h1, 4'hF);
        mem_read(MEM_AW'(8'h20));

        test_name = "back_pressure";
        mem_bready <= 1'b0;
        data = $random(seed);
        send_mem_write(MEM_AW'(8'h24), data, 4'hF);
        do @(posedge clk); while (!mem_bvalid);
        model[9] = data;
        data = $random(seed);
        send_mem_write(MEM_AW'(8'h28), data, 4'hF);
        repeat (3) @(posedge clk);
        mem_read(MEM_AW'(8'h28));
        mem_bready <= 1'b1;
        wait_mem_bresp();
        wait_mem_bresp();
        model[10] = data;
        mem_read(MEM_AW'(8'h28));
        mem_read(MEM_AW'(8'h24));

        repeat (2) @(posedge clk);
        $display("Checks complete: %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* emu_harness.f */
+incdir+verification
common/axil_pkg.sv
common/emu_regs_pkg.sv
src/axil_slave_port.sv
src/emu_ctrl_regs.sv
src/emu_mem.sv
src/emu_top.sv
verification/tb_emu_top.sv

/* run_sim.sh */
#!/bin/sh
# Build tb_emu_top with Verilator, run it, and take the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_emu_top -f emu_harness.f -o tb_emu_top \
    > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_emu_top > sim.log 2>&1

grep -qx "Finished with no errors" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
